// ==== rtl/spi_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi master port shared definitions.
// clock ratio, bus select meaning, control bits and shifter state type.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package spi_pkg;

    // clock ratio
    localparam int unsigned sys_clk_hz      = 50_000_000;  // system clock.
    localparam int unsigned spi_freq_hz     = 5_000_000;   // target sclk.
    localparam int unsigned cycles_per_half = sys_clk_hz / spi_freq_hz / 2;
    localparam int unsigned tick_w          = $clog2(cycles_per_half);

    // meaning of the ctrl select line on the bus
    localparam logic sel_ctrl = 1'b0;  // chip select and mode register.
    localparam logic sel_data = 1'b1;  // byte transfer register.

    // control write bit positions
    localparam int unsigned ctrl_bit_cs   = 0;  // 1 pulls cen low.
    localparam int unsigned ctrl_bit_quad = 1;  // 1 selects four lanes.

    // bits loaded per transfer
    localparam int unsigned byte_bits = 8;

    typedef enum logic {
        sh_idle,
        sh_shifting
    } shift_state_t;

endpackage

// ==== rtl/spi_bus_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// requester bus between the top level and the register bank.
// valid/ready strobe handshake with one select line.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface spi_bus_if;

    logic        ctrl;   // 0 control, 1 data.
    logic        valid;
    logic [3:0]  wstrb;
    logic [31:0] wdata;
    logic        ready;  // single cycle pulse.
    logic [31:0] rdata;  // valid with ready.

    modport requester (
        output ctrl, valid, wstrb, wdata,
        input  ready, rdata
    );

    modport completer (
        input  ctrl, valid, wstrb, wdata,
        output ready, rdata
    );

endinterface

// ==== rtl/spi_xfer_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte transfer command between the register bank and the shift engine.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface spi_xfer_if;

    logic       start;    // one cycle pulse.
    logic       quad;     // lane mode for this byte.
    logic [7:0] tx_byte;
    logic       done;     // one cycle pulse.
    logic [7:0] rx_byte;  // valid with done.

    modport master (
        output start, quad, tx_byte,
        input  done, rx_byte
    );

    modport shifter (
        input  start, quad, tx_byte,
        output done, rx_byte
    );

endinterface

// ==== rtl/spi_sclk_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sclk half period tick generator.
// counts only while a transfer runs and clears when it stops.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spi_sclk_gen (
    input  logic clk,
    input  logic resetn,
    input  logic run,
    output logic tick
);
    import spi_pkg::*;

    logic [tick_w-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!resetn || !run) begin
            cnt  <= '0;                                  // restart each transfer.
            tick <= 1'b0;
        end else if (cnt == tick_w'(cycles_per_half - 1)) begin
            cnt  <= '0;                                  // wrap.
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    // the engine never leaves a tick behind once it stops running.
    assert_tick_needs_run : assert property (
        @(posedge clk) disable iff (!resetn)
        tick |-> run
    );

endmodule

// ==== rtl/spi_shifter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi shift engine.
// drives sclk (mode 3) and the four lanes, samples the received byte
// in single or quad mode.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spi_shifter (
    input  logic           clk,
    input  logic           resetn,
    spi_xfer_if.shifter    xfer,
    input  logic           tick,
    output logic           run,
    output logic           sclk,
    output logic [3:0]     sio_out,
    output logic [3:0]     sio_oe,
    input  logic [3:0]     sio_in
);
    import spi_pkg::*;

    shift_state_t state;
    logic [7:0]   shift_buf;  // out on top, in at bottom.
    logic [3:0]   bit_cnt;    // bits still to sample.
    logic         quad_q;
    logic         done_q;

    assign run          = (state == sh_shifting);
    assign xfer.done    = done_q;
    assign xfer.rx_byte = shift_buf;  // held until the next start.

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= sh_idle;
            bit_cnt <= '0;
            quad_q  <= 1'b0;
            done_q  <= 1'b0;
            sclk    <= 1'b1;                        // mode 3 idle level.
            sio_out <= 4'b0000;
            sio_oe  <= 4'b0001;
        end else begin
            done_q <= 1'b0;
            case (state)
                sh_idle: begin
                    if (xfer.start) begin
                        bit_cnt <= 4'(byte_bits);
                        quad_q  <= xfer.quad;
                        sio_oe  <= xfer.quad ? 4'b1111 : 4'b0001;
                        state   <= sh_shifting;
                    end
                end
                sh_shifting: begin
                    if (bit_cnt == '0) begin
                        done_q <= 1'b1;             // last sample is in.
                        sio_oe <= 4'b0001;
                        state  <= sh_idle;
                    end else if (tick) begin
                        if (sclk) begin
                            // falling edge, present next bits.
                            sclk    <= 1'b0;
                            sio_out <= quad_q ? shift_buf[7:4] : {3'b000, shift_buf[7]};
                        end else begin
                            // rising edge, sample.
                            sclk    <= 1'b1;
                            bit_cnt <= bit_cnt - (quad_q ? 4'd4 : 4'd1);
                        end
                    end
                end
                default: state <= sh_idle;
            endcase
        end
    end

    // byte buffer, loaded on start and shifted on rising ticks.
    always_ff @(posedge clk) begin
        if (state == sh_idle && xfer.start) begin
            shift_buf <= xfer.tx_byte;
        end else if (state == sh_shifting && tick && !sclk && bit_cnt != '0) begin
            shift_buf <= quad_q ? {shift_buf[3:0], sio_in} : {shift_buf[6:0], sio_in[1]};
        end
    end

    // the bit count runs out only on a rising edge, so sclk rests high.
    assert_sclk_idle_high : assert property (
        @(posedge clk) disable iff (!resetn)
        (state == sh_idle) |-> sclk
    );

    // the register bank only starts an idle engine.
    assert_start_idle : assert property (
        @(posedge clk) disable iff (!resetn)
        xfer.start |-> (state == sh_idle)
    );

endmodule

// ==== rtl/spi_reg_bank.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus completer for the spi port.
// chip select, quad flag and received byte registers, access sequencing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spi_reg_bank (
    input  logic         clk,
    input  logic         resetn,
    spi_bus_if.completer bus,
    spi_xfer_if.master   xfer,
    output logic         cen
);
    import spi_pkg::*;

    typedef enum logic [1:0] {
        rb_idle,
        rb_read,   // data read, answer next cycle.
        rb_xfer    // waiting on the shift engine.
    } bank_state_t;

    bank_state_t state;
    logic        cen_q;
    logic        quad_q;
    logic        ready_q;
    logic        start_q;
    logic [7:0]  tx_q;
    logic [7:0]  rx_q;
    logic        accept;

    // ignore valid during our own ready cycle.
    assign accept = (state == rb_idle) && bus.valid && !ready_q;

    assign cen          = cen_q;
    assign bus.ready    = ready_q;
    assign bus.rdata    = (bus.ctrl == sel_data) ? {24'b0, rx_q} : {30'b0, quad_q, cen_q};
    assign xfer.start   = start_q;
    assign xfer.quad    = quad_q;
    assign xfer.tx_byte = tx_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= rb_idle;
            cen_q   <= 1'b1;                   // deselected.
            quad_q  <= 1'b0;
            ready_q <= 1'b0;
            start_q <= 1'b0;
            rx_q    <= 8'h00;
        end else begin
            ready_q <= 1'b0;
            start_q <= 1'b0;
            case (state)
                rb_idle: begin
                    if (accept) begin
                        if (bus.ctrl == sel_ctrl) begin
                            if (bus.wstrb[0]) begin
                                cen_q  <= ~bus.wdata[ctrl_bit_cs];
                                quad_q <= bus.wdata[ctrl_bit_quad];
                            end
                            ready_q <= 1'b1;
                        end else if (bus.wstrb[0]) begin
                            start_q <= 1'b1;   // kick one byte.
                            state   <= rb_xfer;
                        end else begin
                            state <= rb_read;
                        end
                    end
                end
                rb_read: begin
                    ready_q <= 1'b1;
                    state   <= rb_idle;
                end
                rb_xfer: begin
                    if (xfer.done) begin
                        rx_q    <= xfer.rx_byte;
                        ready_q <= 1'b1;
                        state   <= rb_idle;
                    end
                end
                default: state <= rb_idle;
            endcase
        end
    end

    // transmit byte, taken with the data write.
    always_ff @(posedge clk) begin
        if (accept && bus.ctrl == sel_data && bus.wstrb[0]) begin
            tx_q <= bus.wdata[7:0];
        end
    end

    assert_ready_pulse : assert property (
        @(posedge clk) disable iff (!resetn)
        bus.ready |=> !bus.ready
    );

endmodule

// ==== rtl/spi_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory mapped spi master port, top level.
// register bank, shift engine and sclk tick generator.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spi_port (
    input  logic        clk,
    input  logic        resetn,
    input  logic        ctrl,     // 0 control, 1 data.
    input  logic        valid,
    input  logic [3:0]  wstrb,
    input  logic [31:0] wdata,
    output logic        ready,
    output logic [31:0] rdata,
    output logic        cen,
    output logic        sclk,
    output logic [3:0]  sio_out,
    output logic [3:0]  sio_oe,   // pads are added by the board wrapper.
    input  logic [3:0]  sio_in
);

    logic run;
    logic tick;

    spi_bus_if  bus ();
    spi_xfer_if xfer ();

    // requester side of the bus comes straight from the ports.
    assign bus.ctrl  = ctrl;
    assign bus.valid = valid;
    assign bus.wstrb = wstrb;
    assign bus.wdata = wdata;
    assign ready     = bus.ready;
    assign rdata     = bus.rdata;

    spi_reg_bank u_reg_bank (
        .clk    (clk),
        .resetn (resetn),
        .bus    (bus.completer),
        .xfer   (xfer.master),
        .cen    (cen)
    );

    spi_shifter u_shifter (
        .clk     (clk),
        .resetn  (resetn),
        .xfer    (xfer.shifter),
        .tick    (tick),
        .run     (run),
        .sclk    (sclk),
        .sio_out (sio_out),
        .sio_oe  (sio_oe),
        .sio_in  (sio_in)
    );

    spi_sclk_gen u_sclk_gen (
        .clk    (clk),
        .resetn (resetn),
        .run    (run),
        .tick   (tick)
    );

endmodule

// ==== testbench/spi_dev_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral spi slave, mode 3.
// answers 8'ha5 after select, then the inverse of each byte received.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spi_dev_model (
    input  logic cen,
    input  logic sclk,
    input  logic mosi,
    output logic miso
);

    logic [7:0] resp      = 8'ha5;
    logic [7:0] rx_shift  = 8'h00;
    int         nbits     = 0;
    logic       sclk_prev = 1'b1;
    logic       cen_prev  = 1'b1;

    initial begin
        miso = 1'b0;
        forever begin
            @(sclk or cen);
            if (cen_prev && !cen) begin
                resp  = 8'ha5;                    // fresh select.
                nbits = 0;
            end else if (!cen && sclk_prev && !sclk) begin
                miso = resp[7];                   // msb first.
                resp = {resp[6:0], 1'b0};
            end else if (!cen && !sclk_prev && sclk) begin
                rx_shift = {rx_shift[6:0], mosi};
                nbits    = nbits + 1;
                if (nbits == 8) begin
                    resp  = ~rx_shift;            // answer for the next byte.
                    nbits = 0;
                end
            end
            sclk_prev = sclk;
            cen_prev  = cen;
        end
    end

endmodule

// ==== testbench/tb_spi_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the spi master port.
// bus tasks, compare tasks, directed tests, idle monitor and watchdog.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_spi_port;
    import spi_pkg::*;

    localparam int n_bytes    = 16;  // bytes shifted over all tests.
    localparam int timeout_ns = n_bytes * 20 * cycles_per_half * 40 * 4;

    logic        clk = 1'b0;
    logic        resetn;
    logic        ctrl;
    logic        valid;
    logic [3:0]  wstrb;
    logic [31:0] wdata;
    logic        ready;
    logic [31:0] rdata;
    logic        cen;
    logic        sclk;
    logic [3:0]  sio_out;
    logic [3:0]  sio_oe;
    logic [3:0]  sio_in;
    logic        miso;

    int          value_errors = 0;
    int          other_errors = 0;
    int          idle_errors  = 0;
    logic [31:0] lfsr_state   = 32'ha36c;
    logic        exp_cen      = 1'b1;
    logic        exp_quad     = 1'b0;
    logic [7:0]  last_rx      = 8'h00;
    logic        in_xfer      = 1'b0;

    // results of the last bus access
    logic [31:0] acc_rdata;
    int          acc_cycles;
    int          acc_falls;
    logic        acc_all_oe;

    spi_port dut (.*);

    spi_dev_model u_dev (.cen(cen), .sclk(sclk), .mosi(sio_out[0]), .miso(miso));

    // enabled lanes read back the master's own output.
    assign sio_in = (sio_oe & sio_out) | (~sio_oe & {2'b00, miso, 1'b0});

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic next_payload(output logic [7:0] b);
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b = {b[6:0], lfsr_state[0]};           // one step per bit.
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        if (got !== want) begin
            value_errors++;
            $display("** Error %s: got 0x%08h, expected 0x%08h at %0t", name, got, want, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            value_errors++;
            $display("** Error %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    task automatic check_lanes(input string name, input logic [3:0] got,
                               input logic [3:0] want);
        if (got !== want) begin
            value_errors++;
            $display("** Error %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("error: %s at %0t", what, $time);
    endtask

    // one handshake, sampled 1 ns after each rising edge.
    task automatic bus_access(input logic c, input logic [3:0] strb, input logic [31:0] wd);
        logic prev_sclk;
        @(posedge clk);
        #2;
        ctrl       = c;
        valid      = 1'b1;
        wstrb      = strb;
        wdata      = wd;
        acc_cycles = 0;
        acc_falls  = 0;
        acc_all_oe = 1'b1;
        prev_sclk  = sclk;
        do begin
            @(posedge clk);
            #1;
            acc_cycles++;
            if (prev_sclk && !sclk) acc_falls++;
            if (!sclk && sio_oe != 4'b1111) acc_all_oe = 1'b0;
            prev_sclk = sclk;
        end while (!ready);
        acc_rdata = rdata;
        @(posedge clk);
        #2;
        valid = 1'b0;
    endtask

    task automatic ctrl_write(input logic cs, input logic quad);
        logic [31:0] wd;
        wd                = 32'h0;
        wd[ctrl_bit_cs]   = cs;
        wd[ctrl_bit_quad] = quad;
        bus_access(sel_ctrl, 4'b0001, wd);
        exp_cen  = ~cs;
        exp_quad = quad;
        if (acc_cycles != 1) report_failure($sformatf("control write took %0d cycles", acc_cycles));
        check_bit("cen", cen, exp_cen);
        check_word("rdata", acc_rdata, {30'b0, exp_quad, exp_cen});
    endtask

    task automatic ctrl_read();
        bus_access(sel_ctrl, 4'b0000, 32'h0);
        if (acc_cycles != 1) report_failure($sformatf("control read took %0d cycles", acc_cycles));
        check_word("rdata", acc_rdata, {30'b0, exp_quad, exp_cen});
    endtask

    task automatic data_xfer(input logic [7:0] tx, input logic [7:0] want_rx);
        int want_falls;
        want_falls = exp_quad ? 2 : 8;             // four bits or one per period.
        in_xfer = 1'b1;
        bus_access(sel_data, 4'b0001, {24'h0, tx});
        in_xfer = 1'b0;
        if (acc_falls != want_falls) report_failure($sformatf("%0d sclk periods", acc_falls));
        if (exp_quad && !acc_all_oe) report_failure("sio_oe not all ones in a quad transfer");
        check_lanes("sio_oe", sio_oe, 4'b0001);    // lane 0 only between bytes.
        check_word("rdata", acc_rdata, {24'h0, want_rx});
        last_rx = want_rx;
    endtask

    task automatic data_read();
        bus_access(sel_data, 4'b0000, 32'h0);
        if (acc_cycles != 2) report_failure($sformatf("data read took %0d cycles", acc_cycles));
        if (acc_falls != 0) report_failure("sclk toggled during a data read");
        check_word("rdata", acc_rdata, {24'h0, last_rx});
    endtask

    task automatic test_reset_ctrl();
        check_bit("cen", cen, 1'b1);
        check_bit("sclk", sclk, 1'b1);
        check_lanes("sio_oe", sio_oe, 4'b0001);
        check_lanes("sio_out", sio_out, 4'b0000);
        ctrl_read();
        ctrl_write(1'b1, 1'b0);
        ctrl_read();
        ctrl_write(1'b0, 1'b0);
    endtask

    task automatic test_single();
        logic [7:0] tx;
        logic [7:0] want_rx;
        ctrl_write(1'b1, 1'b0);
        want_rx = 8'ha5;
        for (int i = 0; i < 11; i++) begin
            next_payload(tx);
            data_xfer(tx, want_rx);
            want_rx = ~tx;                         // slave echoes the inverse.
        end
    endtask

    task automatic test_quad();
        logic [7:0] tx;
        ctrl_write(1'b1, 1'b1);
        for (int i = 0; i < 4; i++) begin
            next_payload(tx);
            data_xfer(tx, tx);                     // all lanes loop back.
        end
    endtask

    task automatic test_data_read();
        data_read();
        data_read();
    endtask

    task automatic test_reselect();
        ctrl_write(1'b0, 1'b0);
        ctrl_write(1'b1, 1'b0);
        data_xfer(8'h3c, 8'ha5);
        data_read();
    endtask

    // sclk idles high outside transfers.
    always @(negedge clk) begin
        if (resetn === 1'b1 && !in_xfer && sclk !== 1'b1) begin
            idle_errors++;
            $display("error: sclk low with no transfer active at %0t", $time);
        end
    end

    initial begin
        resetn = 1'b0;
        ctrl   = 1'b0;
        valid  = 1'b0;
        wstrb  = 4'h0;
        wdata  = 32'h0;
        repeat (8) @(posedge clk);
        #2;
        resetn = 1'b1;
        test_reset_ctrl();
        test_single();
        test_quad();
        test_data_read();
        test_reselect();
        $display("done: %0d value errors, %0d other errors, %0d idle errors",
                 value_errors, other_errors, idle_errors);
        if (value_errors == 0 && other_errors == 0 && idle_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: tests did not finish within %0d ns", timeout_ns);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== spi_port.f ====
rtl/spi_pkg.sv
rtl/spi_bus_if.sv
rtl/spi_xfer_if.sv
rtl/spi_sclk_gen.sv
rtl/spi_shifter.sv
rtl/spi_reg_bank.sv
rtl/spi_port.sv
testbench/spi_dev_model.sv
testbench/tb_spi_port.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the spi port testbench with verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1
build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_spi_port --Mdir "$build_dir" -o sim_tb -f spi_port.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$log_file"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
